/* build.f */
verilog/motor_pkg.sv
verilog/spi_master.sv
verilog/driver_config.sv
verilog/step_generator.sv
verilog/motor_driver.sv
verif/tb_clock_gen.sv
verif/motor_driver_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= motor_driver_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/motor_driver_tb.sv */
`timescale 1ns/1ps

// Behavioral model of one SPI driver chip
module chip_model (
  input  logic        sclk,
  input  logic        mosi,
  input  logic        cs_sel_n,
  input  logic [7:0]  status,
  output logic        miso,
  output logic [39:0] rx_frame
);

  int out_idx = 0;
  int falls   = 0;

  // The first falling edge comes before the first sampled bit
  always @(negedge sclk or posedge cs_sel_n) begin
    if (cs_sel_n) begin
      out_idx = 0;
      falls   = 0;
    end else begin
      if (falls != 0) begin
        out_idx = out_idx + 1;
      end
      falls = falls + 1;
    end
  end

  assign miso = (out_idx < 8) ? status[3'(7 - out_idx)] : 1'b0;

  initial rx_frame = '0;

  always @(posedge sclk) begin
    if (!cs_sel_n) begin
      rx_frame <= {rx_frame[38:0], mosi};
    end
  end

endmodule

module motor_driver_tb import motor_pkg::*; ();

  localparam int NUM          = 3;
  localparam int SH           = 4;
  localparam int SW           = 64;
  localparam int FRAMES       = NUM * SETUP_COUNT;
  localparam int DONE_TIMEOUT = 20000;

  typedef struct packed {
    logic [7:0] chip;
    reg_write_t frame;
  } exp_frame_t;

  logic          clk_in;
  logic          reset_n_in;
  logic          miso;
  logic          step_enable;
  logic [SW-1:0] speed;
  logic          sclk;
  logic          mosi;
  logic [NUM-1:0] cs_n;
  logic          step;
  logic          config_done;
  logic          config_error;

  logic [7:0]     chip_status [NUM];
  logic [39:0]    rx_frames [NUM];
  logic [NUM-1:0] miso_bits;
  logic [NUM-1:0] cs_n_prev;

  logic [39:0] frame_q [$];
  int          chip_q [$];
  int          frame_num = 0;
  int          frame_errors = 0;
  int          frame_base;
  int          errors;
  int          tests_passed;
  int          tests_failed;
  integer      seed;

  tb_clock_gen #(.PERIOD_NS(20)) u_clk (.clk(clk_in));

  motor_driver #(
    .NUM_DRIVERS (NUM),
    .SCLK_HALF   (SH),
    .SPEED_WIDTH (SW)
  ) dut (
    .clk_in       (clk_in),
    .reset_n_in   (reset_n_in),
    .miso         (miso),
    .step_enable  (step_enable),
    .speed        (speed),
    .sclk         (sclk),
    .mosi         (mosi),
    .cs_n         (cs_n),
    .step         (step),
    .config_done  (config_done),
    .config_error (config_error)
  );

  for (genvar g = 0; g < NUM; g++) begin : g_chip
    chip_model u_chip (
      .sclk     (sclk),
      .mosi     (mosi),
      .cs_sel_n (cs_n[g]),
      .status   (chip_status[g]),
      .miso     (miso_bits[g]),
      .rx_frame (rx_frames[g])
    );
  end

  // Only the selected chip drives miso
  always_comb begin
    miso = 1'b0;
    for (int i = 0; i < NUM; i++) begin
      if (!cs_n[i]) begin
        miso = miso_bits[i];
      end
    end
  end

  function automatic exp_frame_t expected_frame(input int n);
    exp_frame_t e;
    e.chip  = 8'(n / SETUP_COUNT);
    e.frame = SETUP_TABLE[n % SETUP_COUNT];
    return e;
  endfunction

  function automatic logic expected_error();
    logic err;
    err = 1'b0;
    for (int i = 0; i < NUM; i++) begin
      err = err | chip_status[i][1];
    end
    return err;
  endfunction

  function automatic int total_errors();
    return errors + frame_errors;
  endfunction

  // Frame is complete when its chip select rises
  initial cs_n_prev = '1;
  always @(negedge clk_in) begin
    for (int i = 0; i < NUM; i++) begin
      if (cs_n[i] && !cs_n_prev[i]) begin
        frame_q.push_back(rx_frames[i]);
        chip_q.push_back(i);
      end
    end
    cs_n_prev <= cs_n;
  end

  always @(posedge clk_in) begin
    exp_frame_t exp_f;
    reg_write_t got;
    int         chip;
    int         idx;
    while (frame_q.size() > 0) begin
      got  = reg_write_t'(frame_q.pop_front());
      chip = chip_q.pop_front();
      idx  = frame_num - frame_base;
      if (idx >= FRAMES) begin
        $display("Unexpected extra frame %0d on chip %0d", idx, chip);
        frame_errors++;
      end else begin
        exp_f = expected_frame(idx);
        if (32'(chip) != 32'(exp_f.chip)) begin
          $display("ERROR frame %0d cs_n index expected %h actual %h", idx, exp_f.chip, chip);
          frame_errors++;
        end
        if (got.addr != exp_f.frame.addr) begin
          $display("ERROR frame %0d addr expected %h actual %h", idx, exp_f.frame.addr,
                   got.addr);
          frame_errors++;
        end
        if (got.data != exp_f.frame.data) begin
          $display("ERROR frame %0d data expected %h actual %h", idx, exp_f.frame.data,
                   got.data);
          frame_errors++;
        end
      end
      frame_num++;
    end
  end

  task automatic report_test(input string name, input int err_before);
    if (total_errors() == err_before) begin
      tests_passed++;
      $display("%s: PASS", name);
    end else begin
      tests_failed++;
      $display("%s: FAIL", name);
    end
  endtask

  task automatic check_idle_outputs();
    if (cs_n != '1) begin
      $display("ERROR cs_n expected %h actual %h", {NUM{1'b1}}, cs_n);
      errors++;
    end
    // Bus idles with sclk high and mosi low
    if (!sclk || mosi) begin
      $display("ERROR sclk/mosi expected %h actual %h", 2'b10, {sclk, mosi});
      errors++;
    end
    if (step || config_done || config_error) begin
      $display("ERROR step/config_done/config_error expected %h actual %h", 3'h0,
               {step, config_done, config_error});
      errors++;
    end
  endtask

  task automatic apply_reset();
    @(negedge clk_in);
    reset_n_in = 1'b0;
    repeat (10) begin
      @(negedge clk_in);
      check_idle_outputs();
    end
    reset_n_in = 1'b1;
    #2;
    check_idle_outputs();
  endtask

  // Step must stay low while configuration runs
  task automatic wait_config_done();
    for (int cyc = 0; cyc < DONE_TIMEOUT && !config_done; cyc++) begin
      @(negedge clk_in);
      if (!config_done && step) begin
        $display("ERROR step expected %h actual %h", 1'b0, step);
        errors++;
      end
    end
    if (!config_done) begin
      $display("config_done did not rise within %0d cycles", DONE_TIMEOUT);
      errors++;
    end
    repeat (2) @(negedge clk_in);
  endtask

  task automatic measure_step(input logic [SW-1:0] s);
    int limit;
    int hi;
    int lo;
    int cyc;
    limit = 4 * (int'(s) + 1) + 10;
    step_enable = 1'b0;
    repeat (20) begin
      @(negedge clk_in);
      if (step) begin
        $display("ERROR step expected %h actual %h", 1'b0, step);
        errors++;
      end
    end
    speed       = s;
    step_enable = 1'b1;
    for (cyc = 0; cyc < limit && !step; cyc++) begin
      @(negedge clk_in);
    end
    if (!step) begin
      $display("step never rose for speed %0d", s);
      errors++;
    end else begin
      hi = 0;
      lo = 0;
      while (step && hi < limit) begin
        hi++;
        @(negedge clk_in);
      end
      while (!step && lo < limit) begin
        lo++;
        @(negedge clk_in);
      end
      if (hi != int'(s) + 1) begin
        $display("ERROR step high time expected %h actual %h", int'(s) + 1, hi);
        errors++;
      end
      if (hi + lo != 2 * (int'(s) + 1)) begin
        $display("ERROR step period expected %h actual %h", 2 * (int'(s) + 1), hi + lo);
        errors++;
      end
    end
  endtask

  initial begin
    int        err_before;
    logic [SW-1:0] s;
    reset_n_in   = 1'b0;
    step_enable  = 1'b0;
    speed        = '0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    frame_base   = 0;
    seed         = 32'h6c31;
    for (int i = 0; i < NUM; i++) begin
      chip_status[i] = 8'h00;
    end

    err_before = total_errors();
    apply_reset();
    report_test("test 1 reset state", err_before);

    err_before = total_errors();
    wait_config_done();
    if (frame_num - frame_base != FRAMES) begin
      $display("Expected %0d frames but saw %0d", FRAMES, frame_num - frame_base);
      errors++;
    end
    report_test("test 2 configuration frames", err_before);

    err_before = total_errors();
    for (int cyc = 0; cyc < 500; cyc++) begin
      @(negedge clk_in);
      if (cs_n != '1 || !config_done) begin
        $display("Bus activity or lost config_done after configuration finished");
        errors++;
        break;
      end
    end
    report_test("test 3 completion", err_before);

    err_before = total_errors();
    if (config_error != expected_error()) begin
      $display("ERROR config_error expected %h actual %h", expected_error(), config_error);
      errors++;
    end
    chip_status[1] = 8'h02;
    step_enable    = 1'b1;
    frame_base     = frame_num;
    apply_reset();
    wait_config_done();
    if (frame_num - frame_base != FRAMES) begin
      $display("Expected %0d frames but saw %0d", FRAMES, frame_num - frame_base);
      errors++;
    end
    if (config_error != expected_error()) begin
      $display("ERROR config_error expected %h actual %h", expected_error(), config_error);
      errors++;
    end
    report_test("test 4 error reporting", err_before);

    err_before = total_errors();
    for (int k = 0; k < 6; k++) begin
      s = SW'({$random(seed)} % 8);
      measure_step(s);
    end
    step_enable = 1'b0;
    report_test("test 5 step generation", err_before);

    $display("Tests passed %0d failed %0d, errors %0d", tests_passed, tests_failed,
             total_errors());
    if (total_errors() == 0 && tests_failed == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk = ~clk;
    end
  end

endmodule

/* verilog/motor_driver.sv */
`timescale 1ns/1ps

module motor_driver import motor_pkg::*; #(
  parameter int NUM_DRIVERS = 12,
  parameter int SCLK_HALF   = 8,
  parameter int SPEED_WIDTH = 64
) (
  input  logic                   clk_in,
  input  logic                   reset_n_in,
  input  logic                   miso,
  input  logic                   step_enable,
  input  logic [SPEED_WIDTH-1:0] speed,
  output logic                   sclk,
  output logic                   mosi,
  output logic [NUM_DRIVERS-1:0] cs_n,
  output logic                   step,
  output logic                   config_done,
  output logic                   config_error
);

  localparam int IDX_W = idx_width(NUM_DRIVERS);

  // Sequencer to SPI master
  reg_write_t        frame;
  logic [IDX_W-1:0]  cs_index;
  logic              start;

  // SPI master back to sequencer
  logic              ready;
  logic              done;
  spi_status_t       reply_status;

  driver_config #(
    .NUM_DRIVERS (NUM_DRIVERS)
  ) u_driver_config (
    .clk_in       (clk_in),
    .reset_n_in   (reset_n_in),
    .ready        (ready),
    .done         (done),
    .reply_status (reply_status),
    .frame        (frame),
    .cs_index     (cs_index),
    .start        (start),
    .config_done  (config_done),
    .config_error (config_error)
  );

  spi_master #(
    .NUM_DRIVERS (NUM_DRIVERS),
    .SCLK_HALF   (SCLK_HALF)
  ) u_spi_master (
    .clk_in       (clk_in),
    .reset_n_in   (reset_n_in),
    .frame        (frame),
    .cs_index     (cs_index),
    .start        (start),
    .miso         (miso),
    .ready        (ready),
    .done         (done),
    .reply_status (reply_status),
    .sclk         (sclk),
    .mosi         (mosi),
    .cs_n         (cs_n)
  );

  step_generator #(
    .SPEED_WIDTH (SPEED_WIDTH)
  ) u_step_generator (
    .clk_in      (clk_in),
    .reset_n_in  (reset_n_in),
    .speed       (speed),
    .step_enable (step_enable),
    .config_done (config_done),
    .step        (step)
  );

endmodule

/* verilog/step_generator.sv */
`timescale 1ns/1ps

module step_generator #(
  parameter int SPEED_WIDTH = 64
) (
  input  logic                   clk_in,
  input  logic                   reset_n_in,
  input  logic [SPEED_WIDTH-1:0] speed,
  input  logic                   step_enable,
  input  logic                   config_done,
  output logic                   step
);

  logic [SPEED_WIDTH-1:0] div_cnt;
  logic                   run;
  logic                   wrap;

  // No stepping until the drivers are configured
  assign run  = step_enable && config_done;

  // Half period ends after speed+1 cycles
  assign wrap = (div_cnt == speed);

  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      div_cnt <= '0;
    end else if (!run || wrap) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Toggle stage gives a 50% square wave
  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      step <= 1'b0;
    end else if (!run) begin
      step <= 1'b0;
    end else if (wrap) begin
      step <= ~step;
    end
  end

endmodule

/* verilog/driver_config.sv */
`timescale 1ns/1ps

module driver_config import motor_pkg::*; #(
  parameter int NUM_DRIVERS = 12,
  localparam int IDX_W      = idx_width(NUM_DRIVERS)
) (
  input  logic             clk_in,
  input  logic             reset_n_in,
  input  logic             ready,
  input  logic             done,
  input  spi_status_t      reply_status,
  output reg_write_t       frame,
  output logic [IDX_W-1:0] cs_index,
  output logic             start,
  output logic             config_done,
  output logic             config_error
);

  localparam int ENTRY_W = idx_width(SETUP_COUNT);

  typedef enum logic [1:0] {
    ST_ISSUE,
    ST_WAIT,
    ST_DONE
  } state_t;

  state_t               state;
  logic [ENTRY_W-1:0]   entry_idx;
  logic [IDX_W-1:0]     drv_idx;
  logic                 last_entry;
  logic                 last_driver;

  assign last_entry  = (entry_idx == ENTRY_W'(SETUP_COUNT - 1));
  assign last_driver = (drv_idx == IDX_W'(NUM_DRIVERS - 1));

  // Request goes out only while the SPI master is idle
  assign start       = (state == ST_ISSUE) && ready;

  assign frame       = SETUP_TABLE[entry_idx];
  assign cs_index    = drv_idx;
  assign config_done = (state == ST_DONE);

  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      state        <= ST_ISSUE;
      entry_idx    <= '0;
      drv_idx      <= '0;
      config_error <= 1'b0;
    end else begin
      case (state)
        ST_ISSUE: begin
          if (ready) begin
            state <= ST_WAIT;
          end
        end

        ST_WAIT: begin
          if (done) begin
            // Sticky, any driver reporting an error counts
            if (reply_status.driver_error) begin
              config_error <= 1'b1;
            end

            if (last_entry) begin
              entry_idx <= '0;
              if (last_driver) begin
                state <= ST_DONE;
              end else begin
                drv_idx <= drv_idx + 1'b1;
                state   <= ST_ISSUE;
              end
            end else begin
              entry_idx <= entry_idx + 1'b1;
              state     <= ST_ISSUE;
            end
          end
        end

        // All drivers set up, stay here until reset
        ST_DONE: begin
          state <= ST_DONE;
        end

        default: state <= ST_ISSUE;
      endcase
    end
  end

endmodule

/* verilog/spi_master.sv */
`timescale 1ns/1ps

module spi_master import motor_pkg::*; #(
  parameter int NUM_DRIVERS = 12,
  parameter int SCLK_HALF   = 8,
  localparam int IDX_W      = idx_width(NUM_DRIVERS)
) (
  input  logic                   clk_in,
  input  logic                   reset_n_in,
  input  reg_write_t             frame,
  input  logic [IDX_W-1:0]       cs_index,
  input  logic                   start,
  input  logic                   miso,
  output logic                   ready,
  output logic                   done,
  output spi_status_t            reply_status,
  output logic                   sclk,
  output logic                   mosi,
  output logic [NUM_DRIVERS-1:0] cs_n
);

  localparam int FRAME_BITS = $bits(reg_write_t);
  localparam int DIV_W      = idx_width(SCLK_HALF);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_SHIFT,
    ST_HOLD
  } state_t;

  state_t                  state;
  logic [DIV_W-1:0]        div_cnt;
  logic [5:0]              bit_cnt;
  logic [FRAME_BITS-1:0]   tx_shift;
  logic [7:0]              rx_shift;
  logic [IDX_W-1:0]        cs_q;
  spi_status_t             status_q;

  logic tick;
  logic start_accept;
  logic fall_edge;
  logic rise_edge;
  logic frame_end;

  // One half period of sclk has elapsed
  assign tick         = (div_cnt == DIV_W'(SCLK_HALF - 1));
  assign start_accept = start && (state == ST_IDLE);
  assign fall_edge    = tick && ((state == ST_SETUP) || ((state == ST_SHIFT) && sclk));
  assign rise_edge    = tick && (state == ST_SHIFT) && !sclk;
  assign frame_end    = tick && (state == ST_HOLD);

  assign ready        = (state == ST_IDLE);
  assign reply_status = status_q;

  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      state   <= ST_IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      sclk    <= 1'b1;
      mosi    <= 1'b0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;

      if ((state == ST_IDLE) || tick) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end

      case (state)
        ST_IDLE: begin
          if (start_accept) begin
            state   <= ST_SETUP;
            bit_cnt <= '0;
          end
        end
        // Chip select setup before the first falling edge
        ST_SETUP: begin
          if (fall_edge) begin
            state <= ST_SHIFT;
            sclk  <= 1'b0;
            mosi  <= tx_shift[FRAME_BITS-1];
          end
        end
        ST_SHIFT: begin
          if (fall_edge) begin
            sclk <= 1'b0;
            mosi <= tx_shift[FRAME_BITS-1];
          end else if (rise_edge) begin
            sclk    <= 1'b1;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 6'(FRAME_BITS - 1)) begin
              state <= ST_HOLD;
            end
          end
        end
        // Hold chip select one half period after the last rising edge
        ST_HOLD: begin
          if (frame_end) begin
            state <= ST_IDLE;
            mosi  <= 1'b0;
            done  <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (start_accept) begin
      tx_shift <= frame;
      cs_q     <= cs_index;
    end else if (fall_edge) begin
      tx_shift <= {tx_shift[FRAME_BITS-2:0], 1'b0};
    end

    // Status byte is the first eight bits back
    if (rise_edge && (bit_cnt < 6'd8)) begin
      rx_shift <= {rx_shift[6:0], miso};
    end

    if (frame_end) begin
      status_q <= spi_status_t'(rx_shift);
    end
  end

  // One-hot active low select of the addressed chip
  always_comb begin
    cs_n = '1;
    if (state != ST_IDLE) begin
      cs_n[cs_q] = 1'b0;
    end
  end

endmodule

/* verilog/motor_pkg.sv */
package motor_pkg;

  // Added to a register address to mark a write access
  localparam logic [7:0] WRITE_FLAG = 8'h80;

  // General configuration
  localparam logic [7:0] GCONF      = 8'h00;
  localparam logic [7:0] GSTAT      = 8'h01;
  localparam logic [7:0] IOIN       = 8'h04;

  // Velocity dependent driver control
  localparam logic [7:0] IHOLD_IRUN = 8'h10;
  localparam logic [7:0] TPOWERDOWN = 8'h11;
  localparam logic [7:0] TSTEP      = 8'h12;
  localparam logic [7:0] TPWMTHRS   = 8'h13;
  localparam logic [7:0] TCOOLTHRS  = 8'h14;
  localparam logic [7:0] THIGH      = 8'h15;

  localparam logic [7:0] XDIRECT    = 8'h2d;
  localparam logic [7:0] VDCMIN     = 8'h33;

  // Microstep table
  localparam logic [7:0] MSLUT0     = 8'h60;
  localparam logic [7:0] MSLUT1     = 8'h61;
  localparam logic [7:0] MSLUT2     = 8'h62;
  localparam logic [7:0] MSLUT3     = 8'h63;
  localparam logic [7:0] MSLUT4     = 8'h64;
  localparam logic [7:0] MSLUT5     = 8'h65;
  localparam logic [7:0] MSLUT6     = 8'h66;
  localparam logic [7:0] MSLUT7     = 8'h67;
  localparam logic [7:0] MSLUTSEL   = 8'h68;
  localparam logic [7:0] MSLUTSTART = 8'h69;
  localparam logic [7:0] MSCNT      = 8'h6a;
  localparam logic [7:0] MSCURACT   = 8'h6b;

  // Driver and chopper
  localparam logic [7:0] CHOPCONF   = 8'h6c;
  localparam logic [7:0] COOLCONF   = 8'h6d;
  localparam logic [7:0] DCCTRL     = 8'h6e;
  localparam logic [7:0] DRV_STATUS = 8'h6f;
  localparam logic [7:0] PWMCONF    = 8'h70;
  localparam logic [7:0] PWM_SCALE  = 8'h71;
  localparam logic [7:0] ENCM_CTRL  = 8'h72;
  localparam logic [7:0] LOST_STEPS = 8'h73;

  // One SPI frame, sent MSB first
  typedef struct packed {
    logic [7:0]  addr;
    logic [31:0] data;
  } reg_write_t;

  // First byte shifted back by the chip
  typedef struct packed {
    logic [3:0] reserved;
    logic       standstill;
    logic       sg2;
    logic       driver_error;
    logic       reset_flag;
  } spi_status_t;

  localparam int SETUP_COUNT = 6;

  // Power-up register setup, off time 8 and blank time 1
  localparam reg_write_t SETUP_TABLE [SETUP_COUNT] = '{
    '{addr: GCONF + WRITE_FLAG,      data: 32'h0000_0000},
    '{addr: CHOPCONF + WRITE_FLAG,   data: 32'h300c_8188},
    '{addr: IHOLD_IRUN + WRITE_FLAG, data: 32'h0006_1909},
    '{addr: TPOWERDOWN + WRITE_FLAG, data: 32'h0000_000a},
    '{addr: TPWMTHRS + WRITE_FLAG,   data: 32'h0000_01f4},
    '{addr: PWMCONF + WRITE_FLAG,    data: 32'h0004_01c8}
  };

  // Bits needed to index n items
  function automatic int idx_width(input int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

endpackage
